/* sim/cpu_trace.txt */
# P byte_addr word | R reg value | S byte_addr value | H final_pc, all hex
# R and S lines list the retire events in commit order
P 00 A1FF
P 02 B17F
P 04 A201
P 06 0312
P 08 B480
P 0A 1542
P 0C 2614
P 0E 3712
P 10 4824
P 12 5943
P 14 6A21
P 16 7B11
P 18 AC20
P 1A 96C2
P 1C 8DC2
P 1E 93CF
P 20 8ECF
P 22 1F22
P 24 C201
P 26 AF55
P 28 0F12
P 2A CC01
P 2C AF77
P 2E 2F22
P 30 C601
P 32 AF12
P 34 ED00
P 36 AC3C
P 38 DEC0
P 3A AF99
P 3C 0012
P 3E 0F02
P 40 F000
R 1 00FF
R 1 7FFF
R 2 0001
R 3 7FFF
R 4 8000
R 5 8000
R 6 FFFF
R 7 007F
R 8 0010
R 9 F000
R A 8000
R B 7EEE
R C 0020
S 0024 FFFF
R D FFFF
S 001E 7FFF
R E 7FFF
R F 0000
R F 7FFF
R F 0000
R F 0012
R D 0036
R C 003C
R F 0001
H 0040

/* filelist.f */
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/register_file.sv
hw/alu.sv
hw/memory_stage.sv
hw/cpu.sv
sim/clock_gen.sv
sim/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/cpu_tb.sv */
module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  logic    clk;
  logic    rst_n;
  logic    load_busy;
  logic    prog_load;
  word_t   prog_addr;
  word_t   prog_data;
  logic    hlt;
  word_t   pc;
  retire_t retire;

  // program image and expected retire events from the trace
  word_t        prog_addr_q[$];
  word_t        prog_word_q[$];
  retire_kind_e exp_kind_q[$];
  word_t        exp_addr_q[$];
  word_t        exp_data_q[$];
  word_t        final_pc;
  bit           trace_ok;
  int           errors;
  int           checks;
  int           ev_idx;
  int           limit_cycles;

  clock_gen u_clk (
    .hold  (load_busy),
    .clk   (clk),
    .rst_n (rst_n)
  );

  cpu UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_load (prog_load),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .hlt       (hlt),
    .pc        (pc),
    .retire    (retire)
  );

  task automatic check_value(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic read_trace(output bit ok);
    int    fd;
    string line;
    byte   tag;
    word_t a;
    word_t d;
    ok = 1'b0;
    fd = $fopen("sim/cpu_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file sim/cpu_trace.txt");
    end else begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // blank lines and # comments carry no data
        if ((line.len() > 2) && (line[0] != "#")) begin
          void'($sscanf(line, "%c %h %h", tag, a, d));
          case (tag)
            "P": begin
              prog_addr_q.push_back(a);
              prog_word_q.push_back(d);
            end
            "R": begin
              exp_kind_q.push_back(reg_wr);
              exp_addr_q.push_back(a);
              exp_data_q.push_back(d);
            end
            "S": begin
              exp_kind_q.push_back(store);
              exp_addr_q.push_back(a);
              exp_data_q.push_back(d);
            end
            "H": final_pc = a;
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // one retired side effect against the next trace line
  task automatic compare_event();
    if (ev_idx >= exp_data_q.size()) begin
      errors++;
      $display("unexpected retire event at %0d ns, the trace lists no more events", $time);
    end else begin
      check_value($sformatf("event %0d kind", ev_idx), {14'd0, retire.kind},
                  {14'd0, exp_kind_q[ev_idx]});
      check_value($sformatf("event %0d addr", ev_idx), retire.addr, exp_addr_q[ev_idx]);
      check_value($sformatf("event %0d data", ev_idx), retire.data, exp_data_q[ev_idx]);
      ev_idx++;
    end
  endtask

  initial begin
    load_busy = 1'b1;
    prog_load = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    errors = 0;
    checks = 0;
    ev_idx = 0;
    final_pc = '0;
    read_trace(trace_ok);
    if (!trace_ok) begin
      $display("Result: FAILED");
      $finish;
    end else begin
      limit_cycles = 4 * exp_data_q.size() + 50;
      // program load while reset is held
      foreach (prog_word_q[i]) begin
        @(posedge clk);
        #1;
        prog_load = 1'b1;
        prog_addr = prog_addr_q[i];
        prog_data = prog_word_q[i];
      end
      @(posedge clk);
      #1;
      prog_load = 1'b0;
      load_busy = 1'b0;
      wait (rst_n === 1'b1);
      // negedge sampling, one instruction per cycle
      @(negedge clk);
      while (hlt !== 1'b1) begin
        if (retire.kind != none) begin
          compare_event();
        end
        @(negedge clk);
      end
      // pc must stay on the halt word with nothing committed
      repeat (3) @(negedge clk);
      check_value("final pc", pc, final_pc);
      check_value("retire kind after halt", {14'd0, retire.kind}, 16'd0);
      if (ev_idx != exp_data_q.size()) begin
        errors++;
        $display("%0d expected retire events never happened", exp_data_q.size() - ev_idx);
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

  // watchdog, scaled to the number of expected events
  initial begin
    wait (rst_n === 1'b1);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the processor did not halt within %0d cycles", limit_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* sim/clock_gen.sv */
module clock_gen (
  input  logic hold,
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset stays low while the program loads, then 5 more cycles
  initial begin
    rst_n = 1'b0;
    @(posedge clk);
    wait (hold === 1'b0);
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

/* hw/cpu.sv */
module cpu (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             prog_load,
  input  cpu_pkg::word_t   prog_addr,
  input  cpu_pkg::word_t   prog_data,
  output logic             hlt,
  output cpu_pkg::word_t   pc,
  output cpu_pkg::retire_t retire
);
  import cpu_pkg::*;

  word_t  instr;
  ctrl_t  ctrl;
  flags_t flags;
  word_t  rs_data;
  word_t  rt_data;
  word_t  alu_result;
  word_t  wb_data;

  // fetch, pc and program memory
  fetch_stage u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_load (prog_load),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .ctrl      (ctrl),
    .rs_data   (rs_data),
    .pc        (pc),
    .instr     (instr)
  );

  // decode, also resolves the branch against the flags
  decode_stage u_decode (
    .instr (instr),
    .pc    (pc),
    .flags (flags),
    .ctrl  (ctrl)
  );

  register_file u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs_idx     (ctrl.rs),
    .rt_idx     (ctrl.rt),
    .rd_idx     (ctrl.rd),
    .write_en   (ctrl.reg_write),
    .write_data (wb_data),
    .rs_data    (rs_data),
    .rt_data    (rt_data)
  );

  // execute, owns the flag register
  alu u_alu (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .result  (alu_result),
    .flags   (flags)
  );

  // data memory and writeback
  memory_stage u_mem (
    .clk        (clk),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .rt_data    (rt_data),
    .pc         (pc),
    .wb_data    (wb_data),
    .retire     (retire)
  );

  // halt is combinational from the fetched opcode
  assign hlt = ctrl.halt;

endmodule

/* hw/memory_stage.sv */
module memory_stage (
  input  logic             clk,
  input  cpu_pkg::ctrl_t   ctrl,
  input  cpu_pkg::word_t   alu_result,
  input  cpu_pkg::word_t   rt_data,
  input  cpu_pkg::word_t   pc,
  output cpu_pkg::word_t   wb_data,
  output cpu_pkg::retire_t retire
);
  import cpu_pkg::*;

  word_t              dmem [dmem_words];
  logic [dmem_aw-1:0] dmem_idx;
  word_t              load_data;

  // byte address from the alu, word index into the array
  assign dmem_idx = alu_result[dmem_aw:1];
  assign load_data = dmem[dmem_idx];

  always_ff @(posedge clk) begin
    if (ctrl.mem_write) begin
      dmem[dmem_idx] <= rt_data;
    end
  end

  // writeback select
  // llb keeps the high byte of rd, lhb keeps the low byte
  always_comb begin
    if (ctrl.mem_read) begin
      wb_data = load_data;
    end else begin
      case (ctrl.opcode)
        llb:     wb_data = {alu_result[15:8], ctrl.imm[7:0]};
        lhb:     wb_data = {ctrl.imm[7:0], alu_result[7:0]};
        pcs:     wb_data = pc + pc_step;
        default: wb_data = alu_result;
      endcase
    end
  end

  // retire record, writes to r0 are dropped and not reported
  always_comb begin
    retire = '0;
    if (ctrl.mem_write) begin
      retire.kind = store;
      retire.addr = alu_result;
      retire.data = rt_data;
    end else if (ctrl.reg_write && (ctrl.rd != '0)) begin
      retire.kind = reg_wr;
      retire.addr = {12'h000, ctrl.rd};
      retire.data = wb_data;
    end
  end

endmodule

/* hw/alu.sv */
module alu (
  input  logic             clk,
  input  logic             rst_n,
  input  cpu_pkg::ctrl_t   ctrl,
  input  cpu_pkg::word_t   rs_data,
  input  cpu_pkg::word_t   rt_data,
  output cpu_pkg::word_t   result,
  output cpu_pkg::flags_t  flags
);
  import cpu_pkg::*;

  logic [16:0] add_res;
  logic [16:0] sub_res;
  logic        arith_wrap;
  logic        is_compute;
  logic [3:0]  shamt;
  logic [31:0] rot;
  word_t       red_sum;
  word_t       padd_res;
  word_t       mem_addr;

  // saturating 16-bit add, returns {overflow, clamped sum}
  // sub uses the same adder with y inverted and a carry in
  function automatic logic [16:0] add_sat(input word_t x, input word_t y, input logic cin);
    word_t sum;
    logic  wrap;
    sum = x + y + {15'd0, cin};
    wrap = (x[15] == y[15]) && (sum[15] != x[15]);
    if (wrap) begin
      sum = x[15] ? 16'h8000 : 16'h7fff;
    end
    return {wrap, sum};
  endfunction

  // one signed nibble lane of paddsb, clamps to -8..7
  function automatic logic [3:0] nib_sat(input logic [3:0] x, input logic [3:0] y);
    logic [3:0] sum;
    sum = x + y;
    if ((x[3] == y[3]) && (sum[3] != x[3])) begin
      sum = x[3] ? 4'h8 : 4'h7;
    end
    return sum;
  endfunction

  assign add_res = add_sat(rs_data, rt_data, 1'b0);
  assign sub_res = add_sat(rs_data, ~rt_data, 1'b1);
  assign arith_wrap = (ctrl.opcode == sub) ? sub_res[16] : add_res[16];

  // red sums all four bytes as signed values, no clamp
  assign red_sum = {{8{rs_data[15]}}, rs_data[15:8]} + {{8{rs_data[7]}}, rs_data[7:0]}
                 + {{8{rt_data[15]}}, rt_data[15:8]} + {{8{rt_data[7]}}, rt_data[7:0]};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      padd_res[i*4 +: 4] = nib_sat(rs_data[i*4 +: 4], rt_data[i*4 +: 4]);
    end
  end

  assign shamt = ctrl.imm[3:0];
  // rotate right, low half of the doubled word
  assign rot = {rs_data, rs_data} >> shamt;

  // word address: rs with bit 0 cleared plus offset in words
  assign mem_addr = {rs_data[15:1], 1'b0} + {ctrl.imm[14:0], 1'b0};

  always_comb begin
    case (ctrl.opcode)
      add:     result = add_res[15:0];
      sub:     result = sub_res[15:0];
      xor_op:  result = rs_data ^ rt_data;
      red:     result = red_sum;
      sll:     result = rs_data << shamt;
      sra:     result = $signed(rs_data) >>> shamt;
      ror_op:  result = rot[15:0];
      paddsb:  result = padd_res;
      lw, sw:  result = mem_addr;
      // llb and lhb pass the old destination through for the merge
      default: result = rs_data;
    endcase
  end

  assign is_compute = ~ctrl.opcode[3];

  // z on every compute op, v and n only on add and sub
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (is_compute) begin
      flags.z <= (result == '0);
      if ((ctrl.opcode == add) || (ctrl.opcode == sub)) begin
        flags.v <= arith_wrap;
        flags.n <= result[15];
      end
    end
  end

endmodule

/* hw/register_file.sv */
module register_file (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu_pkg::reg_idx_t  rs_idx,
  input  cpu_pkg::reg_idx_t  rt_idx,
  input  cpu_pkg::reg_idx_t  rd_idx,
  input  logic               write_en,
  input  cpu_pkg::word_t     write_data,
  output cpu_pkg::word_t     rs_data,
  output cpu_pkg::word_t     rt_data
);
  import cpu_pkg::*;

  // entry 0 is never written and reads back zero
  word_t regs [16];

  // write commits at the edge that retires the instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (rd_idx != '0)) begin
      regs[rd_idx] <= write_data;
    end
  end

  // asynchronous reads
  // single-cycle datapath, a written value is first read on the next instruction
  // so the array output is always current and no same-cycle path is needed
  assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
  assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

/* hw/decode_stage.sv */
module decode_stage (
  input  cpu_pkg::word_t  instr,
  input  cpu_pkg::word_t  pc,
  input  cpu_pkg::flags_t flags,
  output cpu_pkg::ctrl_t  ctrl
);
  import cpu_pkg::*;

  opcode_e op;
  cond_e   cond;
  logic    is_compute;
  logic    is_byte_load;
  logic    cond_met;
  word_t   b_offset;

  assign op = opcode_e'(instr[15:12]);
  assign cond = cond_e'(instr[11:9]);

  // compute ops occupy the lower half of the opcode space
  assign is_compute = ~instr[15];
  assign is_byte_load = (op == llb) || (op == lhb);

  // 9-bit word offset of b, sign-extended and scaled to bytes
  assign b_offset = {{6{instr[8]}}, instr[8:0], 1'b0};

  // branch condition against the committed flags
  always_comb begin
    case (cond)
      neq:     cond_met = ~flags.z;
      eq:      cond_met = flags.z;
      gt:      cond_met = ~flags.z & ~flags.n;
      lt:      cond_met = flags.n;
      gte:     cond_met = flags.z | ~flags.n;
      lte:     cond_met = flags.n | flags.z;
      ovf:     cond_met = flags.v;
      default: cond_met = 1'b1;
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.opcode = op;
    ctrl.rd = instr[11:8];
    // llb and lhb read their own destination to keep the other byte
    ctrl.rs = is_byte_load ? instr[11:8] : instr[7:4];
    // store data register sits in the rd slot
    ctrl.rt = (op == sw) ? instr[11:8] : instr[3:0];

    case (op)
      // shift amount, zero-extended
      sll, sra, ror_op: ctrl.imm = {12'h000, instr[3:0]};
      // memory word offset, sign-extended, scaled in the alu
      lw, sw:           ctrl.imm = {{12{instr[3]}}, instr[3:0]};
      // byte for the merge in writeback
      llb, lhb:         ctrl.imm = {8'h00, instr[7:0]};
      // full branch target, pc of the next instruction plus offset
      b:                ctrl.imm = pc + pc_step + b_offset;
      default:          ctrl.imm = '0;
    endcase

    ctrl.reg_write = is_compute || (op inside {lw, llb, lhb, pcs});
    ctrl.mem_read = (op == lw);
    ctrl.mem_write = (op == sw);
    ctrl.take_branch = ((op == b) || (op == br)) && cond_met;
    ctrl.branch_reg = (op == br);
    ctrl.halt = (op == hlt);
  end

endmodule

/* hw/fetch_stage.sv */
module fetch_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             prog_load,
  input  cpu_pkg::word_t   prog_addr,
  input  cpu_pkg::word_t   prog_data,
  input  cpu_pkg::ctrl_t   ctrl,
  input  cpu_pkg::word_t   rs_data,
  output cpu_pkg::word_t   pc,
  output cpu_pkg::word_t   instr
);
  import cpu_pkg::*;

  // program storage, word addressed
  word_t imem [imem_words];
  word_t seq_pc;
  word_t next_pc;

  // load port only accepts writes while the core is held in reset
  // byte address, bit 0 ignored
  always_ff @(posedge clk) begin
    if (!rst_n && prog_load) begin
      imem[prog_addr[imem_aw:1]] <= prog_data;
    end
  end

  // combinational instruction read at the current pc
  assign instr = imem[pc[imem_aw:1]];

  assign seq_pc = pc + pc_step;

  // next pc select
  // br jumps to the rs value, b to the target formed in decode
  always_comb begin
    if (ctrl.take_branch) begin
      next_pc = ctrl.branch_reg ? rs_data : ctrl.imm;
    end else begin
      next_pc = seq_pc;
    end
  end

  // pc register
  // hlt freezes it so the halt word stays fetched until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!ctrl.halt) begin
      pc <= next_pc;
    end
  end

endmodule

/* hw/cpu_pkg.sv */
package cpu_pkg;

  // data, address and instruction words share one width
  typedef logic [15:0] word_t;

  // register number, sixteen architectural registers
  typedef logic [3:0] reg_idx_t;

  // instruction opcodes, bits 15:12 of every instruction
  typedef enum logic [3:0] {
    add,
    sub,
    xor_op,
    red,
    sll,
    sra,
    ror_op,
    paddsb,
    lw,
    sw,
    llb,
    lhb,
    b,
    br,
    pcs,
    hlt
  } opcode_e;

  // branch condition, bits 11:9 of b and br
  typedef enum logic [2:0] {
    neq,
    eq,
    gt,
    lt,
    gte,
    lte,
    ovf,
    uncond
  } cond_e;

  // condition flags held by the execute stage
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  // decoded control for one instruction
  // imm already extended; for b it carries the whole branch target
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    imm;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     take_branch;
    logic     branch_reg;
    logic     halt;
  } ctrl_t;

  typedef enum logic [1:0] {
    none,
    reg_wr,
    store
  } retire_kind_e;

  // one committed side effect, seen from outside the core
  // addr is the register number for reg_wr, the byte address for store
  typedef struct packed {
    retire_kind_e kind;
    word_t        addr;
    word_t        data;
  } retire_t;

  // memory sizes in words
  localparam int imem_words = 256;
  localparam int dmem_words = 256;
  localparam int imem_aw = $clog2(imem_words);
  localparam int dmem_aw = $clog2(dmem_words);

  // pc counts bytes, one instruction is two bytes
  localparam word_t pc_step = 16'd2;

endpackage
